// File: include/config.svh
`ifndef CONFIG_SVH
`define CONFIG_SVH

// INMP441 microphone on gpio_0
`define MIC_LR_PIN     0  // J1 pin 36
`define MIC_WS_PIN     2  // J1 pin 34
`define MIC_SCK_PIN    4  // J1 pin 32
`define MIC_SD_PIN     5  // J1 pin 31

// I2S DAC on gpio_0
`define AUD_LRCLK_PIN  6  // J1 pin 30
`define AUD_SDATA_PIN  8  // J1 pin 28
`define AUD_BCLK_PIN  10  // J1 pin 26
`define AUD_MCLK_PIN  12  // J1 pin 24

`endif

// File: src/board_pkg.sv
package board_pkg;

    localparam int w_mic        = 24;  // INMP441 sample width
    localparam int w_sound      = 16;  // DAC sample width
    localparam int w_abcdefgh   = 8;   // Seven segments plus dot
    localparam int n_hex_digits = 4;

    // Active-high pattern, bit 7 is segment a, bit 0 is the dot
    function automatic logic [w_abcdefgh - 1:0] hex_to_abcdefgh (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1110_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;  // F
        endcase
    endfunction

endpackage

// File: src/slow_clk_gen.sv
module slow_clk_gen
#(
    parameter int fast_clk_mhz = 50,
    parameter int slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic arst_n,
    output logic slow_clk
);

    // Cycles per half period of slow_clk
    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int w_cnt       = (half_period > 1) ? $clog2(half_period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (cnt == w_cnt'(half_period - 1)) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;  // Toggle once per half period
        end else begin
            cnt      <= cnt + 1'b1;
        end
    end

    // A slow clock faster than clk / 2 cannot be made
    a_divisor_valid: assert property (@(posedge clk) disable iff (!arst_n)
        half_period >= 1);

endmodule

// File: src/inmp441_mic_i2s_receiver.sv
module inmp441_mic_i2s_receiver
(
    input  logic                          clk,
    input  logic                          arst_n,

    output logic                          lr,
    output logic                          ws,
    output logic                          sck,
    input  logic                          sd,

    output logic [board_pkg::w_mic - 1:0] value
);

    import board_pkg::*;

    // ------------------------------
    // Frame timing
    // ------------------------------

    // cnt[1] is sck (clk / 4), cnt[6:2] the bit in the slot,
    // cnt[7] is ws, so one frame is 256 clk cycles
    localparam int w_cnt     = 8;
    localparam int first_bit = 1;          // One sck after the ws edge
    localparam int last_bit  = w_mic;

    logic [w_cnt - 1:0] cnt;
    logic [        4:0] bit_idx;
    logic               sck_rise;
    logic               in_data;
    logic               slot_end;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    assign sck      = cnt[1];
    assign ws       = cnt[w_cnt - 1];        // Low is the left slot
    assign lr       = 1'b0;                  // Mic strapped to left channel

    assign bit_idx  = cnt[6:2];
    assign sck_rise = (cnt[1:0] == 2'd1);    // sck goes high on this edge
    assign in_data  = !ws && (bit_idx >= 5'(first_bit)) && (bit_idx <= 5'(last_bit));
    assign slot_end = (cnt == 8'd127);       // Last cycle of the left slot

    // ------------------------------
    // Capture
    // ------------------------------

    logic [w_mic - 1:0] shreg;

    always_ff @(posedge clk) begin
        if (sck_rise && in_data)
            shreg <= { shreg[w_mic - 2:0], sd };  // MSB arrives first
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            value <= '0;
        else if (slot_end)
            value <= shreg;                  // Held for the whole next frame
    end

    // The mic expects ws to move with the falling sck edge
    a_ws_on_sck_low: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(ws) |-> !sck);

endmodule

// File: src/i2s_audio_out.sv
module i2s_audio_out
#(
    parameter int clk_mhz = 50
)
(
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic [board_pkg::w_sound - 1:0] data_in,

    output logic                            mclk,
    output logic                            bclk,
    output logic                            lrclk,
    output logic                            sdata
);

    import board_pkg::*;

    // ------------------------------
    // Clock dividers
    // ------------------------------

    // cnt[0] is mclk, cnt[1] is bclk, cnt[5:2] the bit in the slot,
    // cnt[6] is lrclk, giving a 128 cycle frame
    localparam int w_cnt = 7;

    // bclk in kHz and the range accepted by the DAC
    localparam int bclk_khz     = clk_mhz * 1000 / 4;
    localparam int bclk_min_khz = 32;
    localparam int bclk_max_khz = 25_000;

    logic [w_cnt - 1:0] cnt;
    logic               bclk_fall;
    logic               msb_slot;
    logic               frame_end;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    assign mclk      = cnt[0];
    assign bclk      = cnt[1];
    assign lrclk     = cnt[w_cnt - 1];

    assign bclk_fall = (cnt[1:0] == 2'b11);     // bclk drops on this edge
    assign msb_slot  = (cnt[5:2] == 4'd0);      // Next bit period carries the MSB
    assign frame_end = (cnt == {w_cnt{1'b1}});

    // ------------------------------
    // Serializer
    // ------------------------------

    logic [w_sound - 1:0] word;
    logic [w_sound - 2:0] shreg;

    always_ff @(posedge clk) begin
        if (frame_end)
            word <= data_in;                    // Same sample for left and right
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sdata <= 1'b0;
            shreg <= '0;
        end else if (bclk_fall) begin
            if (msb_slot) begin
                sdata <= word[w_sound - 1];
                shreg <= word[w_sound - 2:0];
            end else begin
                sdata <= shreg[w_sound - 2];    // LSB lands on the next lrclk bit
                shreg <= { shreg[w_sound - 3:0], 1'b0 };
            end
        end
    end

    a_sdata_on_bclk_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(sdata) |-> $fell(bclk));

    a_bclk_range: assert property (@(posedge clk) disable iff (!arst_n)
        bclk_khz >= bclk_min_khz && bclk_khz <= bclk_max_khz);

endmodule

// File: src/seven_segment_display.sv
module seven_segment_display
#(
    parameter int w_digit      = 8,
    parameter int refresh_bits = 10
)
(
    input  logic                                     clk,
    input  logic                                     arst_n,

    input  logic [board_pkg::n_hex_digits * 4 - 1:0] number,

    output logic [board_pkg::w_abcdefgh - 1:0]       abcdefgh,
    output logic [w_digit - 1:0]                     digit
);

    import board_pkg::*;

    localparam int w_idx = $clog2(n_hex_digits);

    // ------------------------------
    // Scan
    // ------------------------------

    logic [refresh_bits - 1:0] refresh;
    logic [w_idx - 1:0]        idx;
    logic [w_idx - 1:0]        idx_next;
    logic                      step;

    assign step     = (refresh == {refresh_bits{1'b1}});
    assign idx_next = idx + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            refresh <= '0;
            idx     <= w_idx'(n_hex_digits - 1);  // First step lands on digit 0
            digit   <= '0;                        // All digits dark until then
        end else begin
            refresh <= refresh + 1'b1;
            if (step) begin
                idx   <= idx_next;
                digit <= w_digit'(1) << idx_next;
            end
        end
    end

    // ------------------------------
    // Segment decode
    // ------------------------------

    assign abcdefgh = hex_to_abcdefgh(number[idx * 4 +: 4]);

    // At most one digit driven at a time
    a_digit_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(digit));

endmodule

// File: src/top.sv
module top
#(
    parameter int w_key        = 3,
    parameter int w_led        = 4,
    parameter int w_digit      = 8,
    parameter int refresh_bits = 10
)
(
    input  logic                               clk,
    input  logic                               slow_clk,
    input  logic                               arst_n,

    input  logic [w_key - 1:0]                 key,
    input  logic [board_pkg::w_mic - 1:0]      mic,
    output logic [board_pkg::w_sound - 1:0]    sound,

    output logic [w_led - 1:0]                 led,

    output logic [board_pkg::w_abcdefgh - 1:0] abcdefgh,
    output logic [w_digit - 1:0]               digit
);

    import board_pkg::*;

    // Level meter thresholds on |sound|
    localparam int level_low  = 256;
    localparam int level_mid  = 2048;
    localparam int level_high = 16384;

    // ------------------------------
    // Attenuation
    // ------------------------------

    logic [w_key - 1:0] shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift <= '0;
            sound <= '0;
        end else begin
            shift <= key;
            // Keep the top bits of the mic word, divide by 2^shift
            sound <= $signed(mic[w_mic - 1 -: w_sound]) >>> shift;
        end
    end

    // ------------------------------
    // Level meter
    // ------------------------------

    logic [w_sound:0] magnitude;  // One extra bit so -32768 fits
    logic [      2:0] meter;

    assign magnitude = sound[w_sound - 1] ? -{1'b1, sound} : {1'b0, sound};

    assign meter[0] = (magnitude >= (w_sound + 1)'(level_low));
    assign meter[1] = (magnitude >= (w_sound + 1)'(level_mid));
    assign meter[2] = (magnitude >= (w_sound + 1)'(level_high));

    assign led = w_led'({ slow_clk, meter });  // led[3] blinks with slow_clk

    // ------------------------------
    // Display
    // ------------------------------

    seven_segment_display
    #(
        .w_digit      ( w_digit      ),
        .refresh_bits ( refresh_bits )
    )
    i_display
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .number   ( sound    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// File: src/board_specific_top.sv
`include "config.svh"

module board_specific_top
#(
    parameter int clk_mhz      = 50,
    parameter int slow_clk_hz  = 1,
    parameter int w_key        = 3,
    parameter int w_led        = 4,
    parameter int w_digit      = 8,
    parameter int refresh_bits = 10
)
(
    input  logic                               clk,
    input  logic                               arst_n,

    input  logic                               key2,
    input  logic                               key3,
    input  logic                               key4,

    output logic [w_led - 1:0]                 led,

    output logic [board_pkg::w_abcdefgh - 1:0] seg_data,
    output logic [w_digit - 1:0]               seg_sel,

    inout  wire  [33:0]                        gpio_0
);

    import board_pkg::*;

    logic [w_key - 1:0]      key;
    logic [w_abcdefgh - 1:0] abcdefgh;
    logic [w_digit - 1:0]    digit;
    logic [w_mic - 1:0]      mic;
    logic [w_sound - 1:0]    sound;
    logic                    slow_clk;

    // Board keys and display lines are active low
    assign key      = w_key'(~{ key2, key3, key4 });
    assign seg_data = ~abcdefgh;
    assign seg_sel  = ~digit;

    // ------------------------------
    slow_clk_gen #(.fast_clk_mhz (clk_mhz), .slow_clk_hz (slow_clk_hz))
    i_slow_clk_gen (.clk (clk), .arst_n (arst_n), .slow_clk (slow_clk));

    // ------------------------------
    top
    #(
        .w_key        ( w_key        ),
        .w_led        ( w_led        ),
        .w_digit      ( w_digit      ),
        .refresh_bits ( refresh_bits )
    )
    i_top
    (
        .clk      ( clk      ),
        .slow_clk ( slow_clk ),
        .arst_n   ( arst_n   ),
        .key      ( key      ),
        .mic      ( mic      ),
        .sound    ( sound    ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    // ------------------------------
    inmp441_mic_i2s_receiver i_microphone
    (
        .clk    ( clk                     ),
        .arst_n ( arst_n                  ),
        .lr     ( gpio_0 [`MIC_LR_PIN ]   ),
        .ws     ( gpio_0 [`MIC_WS_PIN ]   ),
        .sck    ( gpio_0 [`MIC_SCK_PIN]   ),
        .sd     ( gpio_0 [`MIC_SD_PIN ]   ),
        .value  ( mic                     )
    );

    i2s_audio_out #(.clk_mhz (clk_mhz)) o_audio
    (
        .clk     ( clk                      ),
        .arst_n  ( arst_n                   ),
        .data_in ( sound                    ),
        .mclk    ( gpio_0 [`AUD_MCLK_PIN ]  ),
        .bclk    ( gpio_0 [`AUD_BCLK_PIN ]  ),
        .lrclk   ( gpio_0 [`AUD_LRCLK_PIN]  ),
        .sdata   ( gpio_0 [`AUD_SDATA_PIN]  )
    );

endmodule

// File: bench/tb_board_specific_top.sv
`include "config.svh"

module tb_board_specific_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 40 * 256 + 512;  // 40 mic frames plus margin

    // Active-high segments of 0..F, nibble 0 in the low byte
    localparam logic [127:0] seg_rom = 128'h8e9e_7a9c_3eee_e6fe_e0be_b666_f2da_60fc;

    logic        clk;
    logic        arst_n;
    logic        key2;
    logic        key3;
    logic        key4;
    logic [3:0]  led;
    logic [7:0]  seg_data;
    logic [7:0]  seg_sel;
    wire  [33:0] gpio_0;
    logic        mic_sd;

    assign gpio_0[`MIC_SD_PIN] = mic_sd;

    board_specific_top
    #(
        .clk_mhz      ( 1     ),
        .slow_clk_hz  ( 50000 ),
        .refresh_bits ( 4     )
    )
    DUT
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .key2     ( key2     ),
        .key3     ( key3     ),
        .key4     ( key4     ),
        .led      ( led      ),
        .seg_data ( seg_data ),
        .seg_sel  ( seg_sel  ),
        .gpio_0   ( gpio_0   )
    );

    always #2 clk = ~clk;

    // ------------------------------
    // Reference model
    // ------------------------------

    logic [31:0] lfsr = 32'h5f94_acfc;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return { s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0] };  // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic draw_sample(output logic [23:0] v);
        int n;
        for (n = 0; n < 24; n++) begin
            lfsr = lfsr_next(lfsr);
            v    = { v[22:0], lfsr[0] };
        end
    endtask

    // Top 16 bits of the sample divided by 2^shift, rounded toward minus infinity
    function automatic logic [15:0] ref_sound(input logic [23:0] sample, input int shift);
        int v;
        int div;
        v   = $signed(sample[23:8]);
        div = 1 << shift;
        if (v < 0)
            v = (v - div + 1) / div;
        else
            v = v / div;
        return 16'(v);
    endfunction

    function automatic logic [2:0] ref_meter(input logic [15:0] s);
        int mag;
        mag = $signed(s);
        if (mag < 0)
            mag = -mag;
        return { mag >= 16384, mag >= 2048, mag >= 256 };
    endfunction

    // ------------------------------
    // Microphone model and I2S capture
    // ------------------------------

    logic [23:0] samples [$];
    logic [23:0] mic_word;
    int          mic_pos = 0;

    always @(negedge gpio_0[`MIC_SCK_PIN]) begin
        if (arst_n === 1'b1) begin
            mic_pos = (mic_pos + 1) % 64;        // sck period now starting
            if (mic_pos == 1) begin
                draw_sample(mic_word);
                samples.push_back(mic_word);
            end
            if (mic_pos >= 1 && mic_pos <= 24)
                mic_sd <= mic_word[24 - mic_pos];  // MSB first
            else
                mic_sd <= 1'b0;
        end
    end

    logic [31:0] aud_bits;
    logic [15:0] cap_left  [$];
    logic [15:0] cap_right [$];
    logic [2:0]  cap_led   [$];
    int          aud_rise    = 0;
    int          frames_done = 0;
    int          pin_errs    = 0;

    always @(posedge gpio_0[`AUD_BCLK_PIN]) begin
        if (arst_n === 1'b1) begin
            // Slot clocks against the bit period count
            if (gpio_0[`AUD_LRCLK_PIN] !== (aud_rise % 32 >= 16))
                report_mismatch("i2s_pins lrclk", aud_rise % 32 >= 16,
                                gpio_0[`AUD_LRCLK_PIN], pin_errs);
            if (gpio_0[`MIC_WS_PIN] !== (aud_rise % 64 >= 32))
                report_mismatch("i2s_pins ws", aud_rise % 64 >= 32,
                                gpio_0[`MIC_WS_PIN], pin_errs);
            if (gpio_0[`MIC_LR_PIN] !== 1'b0)
                report_mismatch("i2s_pins lr", 0, gpio_0[`MIC_LR_PIN], pin_errs);
            aud_bits = { aud_bits[30:0], gpio_0[`AUD_SDATA_PIN] };
            if (aud_rise % 32 == 16) begin
                cap_left.push_back(aud_bits[15:0]);  // Bit periods 1 to 16
                cap_led.push_back(led[2:0]);
            end
            if (aud_rise % 32 == 0 && aud_rise > 0) begin
                cap_right.push_back(aud_bits[15:0]);
                frames_done++;
            end
            aud_rise++;
        end
    end

    logic mclk_prev;

    always @(negedge clk) begin
        if (aud_rise > 0 && gpio_0[`AUD_MCLK_PIN] === mclk_prev) begin
            $display("i2s_pins: mclk did not toggle within one clk cycle");
            pin_errs++;
        end
        mclk_prev = gpio_0[`AUD_MCLK_PIN];
    end

    int cycles = 0;

    always @(posedge clk) begin
        cycles++;
        if (cycles == max_cycles) begin
            $display("Timeout: run did not end within %0d cycles", max_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    int n_tests  = 0;
    int n_failed = 0;
    int n_errors = 0;

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv, inout int errs);
        $display("ERROR %s: expected %h, actual %h", name, expv, actv);
        errs++;
    endtask

    task automatic finish_test(input string name, input int errs);
        n_tests++;
        n_errors += errs;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic check_idle_outputs(input string name, inout int errs);
        if (led !== 4'b0)
            report_mismatch({name, " led"}, 0, led, errs);
        if (seg_sel !== 8'hff)
            report_mismatch({name, " seg_sel"}, 8'hff, seg_sel, errs);
        if (gpio_0[`AUD_SDATA_PIN] !== 1'b0)
            report_mismatch({name, " sdata"}, 0, gpio_0[`AUD_SDATA_PIN], errs);
    endtask

    int          errs;
    int          level_errs;
    int          k;
    int          f;
    int          f0;
    int          i;
    int          d;
    int          last_toggle;
    int          n_toggles;
    logic        prev_slow;
    logic [3:0]  seen;
    logic [3:0]  nib;
    logic [7:0]  sel;
    logic [7:0]  exp_seg;
    logic [15:0] exp_word;

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        key2   = 1'b1;  // Released keys give attenuation 0
        key3   = 1'b1;
        key4   = 1'b1;
        mic_sd = 1'b0;

        errs = 0;
        @(posedge clk);
        @(negedge clk);
        check_idle_outputs("reset", errs);
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("reset", errs);  // Before the first sdata bit
        end
        finish_test("reset", errs);

        // Sound is stable from the start of an odd audio frame for ~255 cycles
        f0 = frames_done;
        wait (frames_done > f0 && frames_done % 2 == 1);
        @(negedge clk);
        exp_word    = ref_sound(samples[(frames_done - 1) / 2], 0);
        errs        = 0;
        level_errs  = 0;
        last_toggle = -1;
        n_toggles   = 0;
        seen        = 4'b0;
        prev_slow   = led[3];
        for (i = 0; i < 80; i++) begin
            @(negedge clk);
            sel = ~seg_sel;
            if (sel[7:4] != 4'b0) begin
                $display("display: a select line of digits 4 to 7 went low");
                errs++;
            end
            for (d = 0; d < 4; d++) begin
                if (sel == (8'd1 << d)) begin
                    seen[d] = 1'b1;
                    nib     = exp_word[d * 4 +: 4];
                    exp_seg = ~seg_rom[nib * 8 +: 8];
                    if (seg_data !== exp_seg)
                        report_mismatch($sformatf("display digit %0d", d), exp_seg,
                                        seg_data, errs);
                end
            end
            if (led[3] !== prev_slow) begin
                if (last_toggle >= 0 && (i - last_toggle < 9 || i - last_toggle > 11)) begin
                    $display("slow_clk: led 3 toggled after %0d cycles, not 10",
                             i - last_toggle);
                    level_errs++;
                end
                last_toggle = i;
                n_toggles++;
                prev_slow   = led[3];
            end
        end
        if (seen != 4'b1111) begin
            $display("display: digits 0 to 3 were not all scanned");
            errs++;
        end
        if (n_toggles < 6) begin
            $display("slow_clk: led 3 toggled only %0d times", n_toggles);
            level_errs++;
        end
        finish_test("display", errs);
        finish_test("slow_clk", level_errs);

        for (k = 0; k < 8; k++) begin
            @(posedge clk);
            { key2, key3, key4 } <= ~3'(k);
            f0         = frames_done;
            errs       = 0;
            level_errs = 0;
            wait (frames_done >= f0 + 8);
            for (f = f0 + 2; f <= f0 + 7; f++) begin
                exp_word = ref_sound(samples[f / 2 - 1], k);  // Previous mic frame
                if (cap_left[f] !== exp_word)
                    report_mismatch($sformatf("atten_key%0d left", k), exp_word,
                                    cap_left[f], errs);
                if (cap_right[f] !== exp_word)
                    report_mismatch($sformatf("atten_key%0d right", k), exp_word,
                                    cap_right[f], errs);
                if (f % 2 == 0 && cap_led[f] !== ref_meter(exp_word))
                    report_mismatch($sformatf("level_key%0d", k), ref_meter(exp_word),
                                    cap_led[f], level_errs);
            end
            finish_test($sformatf("atten_key%0d", k), errs);
            finish_test($sformatf("level_key%0d", k), level_errs);
        end

        finish_test("i2s_pins", pin_errs);

        $display("Tests: %0d run, %0d failed, %0d errors", n_tests, n_failed, n_errors);
        if (n_failed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
src/board_pkg.sv
src/slow_clk_gen.sv
src/inmp441_mic_i2s_receiver.sv
src/i2s_audio_out.sv
src/seven_segment_display.sv
src/top.sv
src/board_specific_top.sv
bench/tb_board_specific_top.sv
